/* logic/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    // datapath widths
    localparam int xlen       = 64;
    localparam int inst_w     = 32;
    localparam int op_w       = 24;
    localparam int alu_mode_w = 8;

    // decoded opcodes, one-hot-ish codes from the decode stage
    localparam logic [op_w-1:0] op_none   = 24'h000000;
    localparam logic [op_w-1:0] op_lui    = 24'h000100;
    localparam logic [op_w-1:0] op_auipc  = 24'h000200;
    localparam logic [op_w-1:0] op_jal    = 24'h000300;
    localparam logic [op_w-1:0] op_jalr   = 24'd4;
    // conditional branches
    localparam logic [op_w-1:0] op_beq    = 24'd5;
    localparam logic [op_w-1:0] op_bne    = 24'd6;
    localparam logic [op_w-1:0] op_blt    = 24'd7;
    localparam logic [op_w-1:0] op_bge    = 24'd8;
    localparam logic [op_w-1:0] op_bltu   = 24'd9;
    localparam logic [op_w-1:0] op_bgeu   = 24'd10;
    // register-immediate ops
    localparam logic [op_w-1:0] op_addi   = 24'd19;
    localparam logic [op_w-1:0] op_slti   = 24'd20;
    localparam logic [op_w-1:0] op_sltiu  = 24'd21;
    localparam logic [op_w-1:0] op_xori   = 24'd22;
    localparam logic [op_w-1:0] op_ori    = 24'd23;
    localparam logic [op_w-1:0] op_andi   = 24'd24;
    localparam logic [op_w-1:0] op_slli   = 24'h000400;
    localparam logic [op_w-1:0] op_srli   = 24'h000800;
    localparam logic [op_w-1:0] op_srai   = 24'h000c00;
    // register-register ops
    localparam logic [op_w-1:0] op_add    = 24'h004000;
    localparam logic [op_w-1:0] op_sub    = 24'h005000;
    localparam logic [op_w-1:0] op_sll    = 24'h006000;
    localparam logic [op_w-1:0] op_slt    = 24'h007000;
    localparam logic [op_w-1:0] op_sltu   = 24'h008000;
    localparam logic [op_w-1:0] op_xor    = 24'h009000;
    localparam logic [op_w-1:0] op_srl    = 24'h010000;
    localparam logic [op_w-1:0] op_or     = 24'h012000;
    localparam logic [op_w-1:0] op_and    = 24'h013000;
    // memory and system
    localparam logic [op_w-1:0] op_ld     = 24'd42;
    localparam logic [op_w-1:0] op_sd     = 24'd43;
    localparam logic [op_w-1:0] op_csrrw  = 24'd49;
    localparam logic [op_w-1:0] op_csrrs  = 24'd50;
    localparam logic [op_w-1:0] op_ecall  = 24'h200000;
    localparam logic [op_w-1:0] op_mret   = 24'h500000;

    // ALU mode codes
    localparam logic [alu_mode_w-1:0] alu_add  = 8'd0;
    localparam logic [alu_mode_w-1:0] alu_sub  = 8'd1;
    localparam logic [alu_mode_w-1:0] alu_slt  = 8'd2;
    localparam logic [alu_mode_w-1:0] alu_sltu = 8'd3;
    localparam logic [alu_mode_w-1:0] alu_and  = 8'd4;
    localparam logic [alu_mode_w-1:0] alu_or   = 8'd6;
    localparam logic [alu_mode_w-1:0] alu_xor  = 8'd7;
    localparam logic [alu_mode_w-1:0] alu_sll  = 8'd8;
    localparam logic [alu_mode_w-1:0] alu_srl  = 8'd9;
    localparam logic [alu_mode_w-1:0] alu_sra  = 8'd10;

    // machine csr addresses
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;
    localparam logic [11:0] csr_mstatus = 12'h300;

    // environment call from m-mode
    localparam logic [xlen-1:0] cause_ecall_m = 64'd11;

    // i-type view, low six bits of csr double as shamt
    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // b-type view with the scattered offset bits
    typedef struct packed {
        logic        imm12;
        logic [5:0]  imm10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm4_1;
        logic        imm11;
        logic [6:0]  opcode;
    } inst_b_t;

    typedef union packed {
        inst_i_t i_view;
        inst_b_t b_view;
    } inst_u;

endpackage

`default_nettype wire

/* logic/ex_bus_if.sv */
`default_nettype none

interface ex_bus_if;
    import ex_pkg::*;

    // registered instruction bundle, valid is a plain level
    logic            valid;
    logic [xlen-1:0] pc;
    inst_u           inst;
    // already forced to op_none on an empty slot
    logic [op_w-1:0] opcode;
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] imm;

    // stage register side
    modport stage (output valid, pc, inst, opcode, src_a, src_b, imm);
    // read-only consumers
    modport user (input valid, pc, inst, opcode, src_a, src_b, imm);

endinterface

`default_nettype wire

/* logic/ex_stage_reg.sv */
`default_nettype none

module ex_stage_reg (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       valid,
    input  logic [ex_pkg::xlen-1:0]    pc,
    input  ex_pkg::inst_u              inst,
    input  logic [ex_pkg::op_w-1:0]    opcode,
    input  logic [ex_pkg::xlen-1:0]    src_a,
    input  logic [ex_pkg::xlen-1:0]    src_b,
    input  logic [ex_pkg::xlen-1:0]    imm,
    ex_bus_if.stage                    bus
);
    import ex_pkg::*;

    logic            valid_q;
    logic [op_w-1:0] opcode_q;

    // id/ex register, one instruction per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q   <= 1'b0;
            opcode_q  <= op_none;
            bus.pc    <= '0;
            bus.inst  <= '0;
            bus.src_a <= '0;
            bus.src_b <= '0;
            bus.imm   <= '0;
        end else begin
            valid_q   <= valid;
            opcode_q  <= opcode;
            bus.pc    <= pc;
            bus.inst  <= inst;
            bus.src_a <= src_a;
            bus.src_b <= src_b;
            bus.imm   <= imm;
        end
    end

    assign bus.valid  = valid_q;
    // empty slot looks like a nop downstream
    assign bus.opcode = valid_q ? opcode_q : op_none;

endmodule

`default_nettype wire

/* logic/ex_operand_mux.sv */
`default_nettype none

module ex_operand_mux (
    ex_bus_if.user                          bus,
    output logic [ex_pkg::xlen-1:0]         operand_a,
    output logic [ex_pkg::xlen-1:0]         operand_b,
    output logic [ex_pkg::alu_mode_w-1:0]   mode
);
    import ex_pkg::*;

    logic [xlen-1:0] shamt_imm;
    logic [xlen-1:0] shamt_reg;

    // shamt from the i-type field, or rs2 low bits
    assign shamt_imm = {{(xlen-6){1'b0}}, bus.inst.i_view.csr[5:0]};
    assign shamt_reg = {{(xlen-6){1'b0}}, bus.src_b[5:0]};

    always_comb begin
        // operand a
        case (bus.opcode)
            op_lui:          operand_a = '0;
            op_auipc,
            op_jal:          operand_a = bus.pc;
            default:         operand_a = bus.src_a;
        endcase

        // operand b
        case (bus.opcode)
            op_slli, op_srli, op_srai:
                operand_b = shamt_imm;
            op_sll, op_srl:
                operand_b = shamt_reg;
            op_lui, op_auipc, op_jal, op_jalr,
            op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
            op_ld, op_sd:
                operand_b = bus.imm;
            default:
                operand_b = bus.src_b;
        endcase

        // alu mode, add covers lui/auipc/jumps/addresses
        case (bus.opcode)
            op_sub,
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
                mode = alu_sub;
            op_slt, op_slti:             mode = alu_slt;
            op_sltu, op_sltiu:           mode = alu_sltu;
            op_and, op_andi:             mode = alu_and;
            // csrrs sets bits: old | rs1
            op_or, op_ori, op_csrrs:     mode = alu_or;
            op_xor, op_xori:             mode = alu_xor;
            op_sll, op_slli:             mode = alu_sll;
            op_srl, op_srli:             mode = alu_srl;
            op_srai:                     mode = alu_sra;
            default:                     mode = alu_add;
        endcase
    end

endmodule

`default_nettype wire

/* logic/ex_alu.sv */
`default_nettype none

module ex_alu (
    input  logic [ex_pkg::alu_mode_w-1:0] mode,
    input  logic [ex_pkg::xlen-1:0]       operand_a,
    input  logic [ex_pkg::xlen-1:0]       operand_b,
    output logic [ex_pkg::xlen-1:0]       result
);
    import ex_pkg::*;

    logic [5:0] shamt;

    // 64-bit shifts only need six bits
    assign shamt = operand_b[5:0];

    always_comb begin
        case (mode)
            alu_add:  result = operand_a + operand_b;
            alu_sub:  result = operand_a - operand_b;
            // set-less-than, result is 1 or 0
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, operand_a < operand_b};
            alu_and:  result = operand_a & operand_b;
            alu_or:   result = operand_a | operand_b;
            alu_xor:  result = operand_a ^ operand_b;
            alu_sll:  result = operand_a << shamt;
            alu_srl:  result = operand_a >> shamt;
            alu_sra:  result = $signed(operand_a) >>> shamt;
            // unknown mode
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/ex_branch_unit.sv */
`default_nettype none

module ex_branch_unit (
    ex_bus_if.user                     bus,
    input  logic [ex_pkg::xlen-1:0]    alu_result,
    output logic [ex_pkg::xlen-1:0]    dnpc,
    output logic                       pc_update
);
    import ex_pkg::*;

    logic [xlen-1:0] snpc;
    logic [xlen-1:0] b_offset;
    logic [xlen-1:0] b_target;

    // sequential next pc
    assign snpc = bus.pc + xlen'(4);

    // reassemble the b-type offset, sign extended
    assign b_offset = {{(xlen-13){bus.inst.b_view.imm12}}, bus.inst.b_view.imm12,
                       bus.inst.b_view.imm11, bus.inst.b_view.imm10_5,
                       bus.inst.b_view.imm4_1, 1'b0};
    assign b_target = bus.pc + b_offset;

    always_comb begin
        pc_update = 1'b1;
        case (bus.opcode)
            op_jal:   dnpc = alu_result;
            // jalr target has bit 0 cleared
            op_jalr:  dnpc = {alu_result[xlen-1:1], 1'b0};
            // alu does src_a - src_b for the signed compares
            op_beq:   dnpc = (alu_result == '0) ? b_target : snpc;
            op_bne:   dnpc = (alu_result != '0) ? b_target : snpc;
            op_blt:   dnpc = alu_result[xlen-1] ? b_target : snpc;
            op_bge:   dnpc = !alu_result[xlen-1] ? b_target : snpc;
            op_bltu:  dnpc = (bus.src_a < bus.src_b) ? b_target : snpc;
            op_bgeu:  dnpc = (bus.src_a >= bus.src_b) ? b_target : snpc;
            // src_a holds mtvec or mepc here
            op_ecall,
            op_mret:  dnpc = bus.src_a;
            default: begin
                dnpc      = snpc;
                pc_update = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/ex_csr_ctrl.sv */
`default_nettype none

module ex_csr_ctrl (
    ex_bus_if.user                     bus,
    input  logic [ex_pkg::xlen-1:0]    alu_result,
    output logic                       wen_mtvec,
    output logic                       wen_mepc,
    output logic                       wen_mcause,
    output logic                       wen_mstatus,
    output logic [ex_pkg::xlen-1:0]    wdata_mtvec,
    output logic [ex_pkg::xlen-1:0]    wdata_mepc,
    output logic [ex_pkg::xlen-1:0]    wdata_mcause,
    output logic [ex_pkg::xlen-1:0]    wdata_mstatus
);
    import ex_pkg::*;

    logic [11:0]     csr_addr;
    logic [xlen-1:0] csr_val;
    logic            csr_op;

    assign csr_addr = bus.inst.i_view.csr;
    assign csr_op   = (bus.opcode == op_csrrw) || (bus.opcode == op_csrrs);
    // csrrw takes rs1, csrrs takes old | rs1 from the alu
    assign csr_val  = (bus.opcode == op_csrrw) ? bus.src_a : alu_result;

    always_comb begin
        wen_mtvec   = csr_op && (csr_addr == csr_mtvec);
        wen_mstatus = csr_op && (csr_addr == csr_mstatus);
        wen_mepc    = csr_op && (csr_addr == csr_mepc);
        wen_mcause  = csr_op && (csr_addr == csr_mcause);
        wdata_mepc   = csr_val;
        wdata_mcause = csr_val;

        // ecall saves the trapping pc and the cause
        if (bus.opcode == op_ecall) begin
            wen_mepc     = 1'b1;
            wen_mcause   = 1'b1;
            wdata_mepc   = bus.pc;
            wdata_mcause = cause_ecall_m;
        end

        // data held at zero unless its enable is up
        wdata_mtvec   = wen_mtvec   ? csr_val      : '0;
        wdata_mstatus = wen_mstatus ? csr_val      : '0;
        wdata_mepc    = wen_mepc    ? wdata_mepc   : '0;
        wdata_mcause  = wen_mcause  ? wdata_mcause : '0;
    end

endmodule

`default_nettype wire

/* logic/ex_stage.sv */
`default_nettype none

module ex_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid_id_ex,
    input  logic [ex_pkg::xlen-1:0]       pc_id_ex,
    input  logic [ex_pkg::inst_w-1:0]     inst_id_ex,
    input  logic [ex_pkg::op_w-1:0]       opcode_id_ex,
    input  logic [ex_pkg::xlen-1:0]       src_a,
    input  logic [ex_pkg::xlen-1:0]       src_b,
    input  logic [ex_pkg::xlen-1:0]       imm,
    output logic                          valid_ex_mem,
    output logic [ex_pkg::xlen-1:0]       pc_ex_mem,
    output logic [ex_pkg::inst_w-1:0]     inst_ex_mem,
    output logic [ex_pkg::op_w-1:0]       opcode_ex_mem,
    output logic [ex_pkg::xlen-1:0]       alu_out_ex_mem,
    output logic [ex_pkg::xlen-1:0]       src_b_ex_mem,
    output logic [ex_pkg::xlen-1:0]       dnpc,
    output logic                          pc_update,
    output logic                          csr_wen_mtvec,
    output logic                          csr_wen_mepc,
    output logic                          csr_wen_mcause,
    output logic                          csr_wen_mstatus,
    output logic [ex_pkg::xlen-1:0]       csr_wdata_mtvec,
    output logic [ex_pkg::xlen-1:0]       csr_wdata_mepc,
    output logic [ex_pkg::xlen-1:0]       csr_wdata_mcause,
    output logic [ex_pkg::xlen-1:0]       csr_wdata_mstatus
);
    import ex_pkg::*;

    logic [xlen-1:0]       operand_a;
    logic [xlen-1:0]       operand_b;
    logic [alu_mode_w-1:0] alu_mode;
    logic [xlen-1:0]       alu_result;

    // registered bundle shared by all consumers
    ex_bus_if ex_bus ();

    ex_stage_reg i_stage_reg (
        .clk    (clk),
        .rst    (rst),
        .valid  (valid_id_ex),
        .pc     (pc_id_ex),
        .inst   (inst_id_ex),
        .opcode (opcode_id_ex),
        .src_a  (src_a),
        .src_b  (src_b),
        .imm    (imm),
        .bus    (ex_bus.stage)
    );

    ex_operand_mux i_operand_mux (
        .bus       (ex_bus.user),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .mode      (alu_mode)
    );

    ex_alu i_alu (
        .mode      (alu_mode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (alu_result)
    );

    ex_branch_unit i_branch_unit (
        .bus        (ex_bus.user),
        .alu_result (alu_result),
        .dnpc       (dnpc),
        .pc_update  (pc_update)
    );

    ex_csr_ctrl i_csr_ctrl (
        .bus           (ex_bus.user),
        .alu_result    (alu_result),
        .wen_mtvec     (csr_wen_mtvec),
        .wen_mepc      (csr_wen_mepc),
        .wen_mcause    (csr_wen_mcause),
        .wen_mstatus   (csr_wen_mstatus),
        .wdata_mtvec   (csr_wdata_mtvec),
        .wdata_mepc    (csr_wdata_mepc),
        .wdata_mcause  (csr_wdata_mcause),
        .wdata_mstatus (csr_wdata_mstatus)
    );

    // to the memory stage, opcode is the gated one
    assign valid_ex_mem   = ex_bus.valid;
    assign pc_ex_mem      = ex_bus.pc;
    assign inst_ex_mem    = ex_bus.inst;
    assign opcode_ex_mem  = ex_bus.opcode;
    assign alu_out_ex_mem = alu_result;
    assign src_b_ex_mem   = ex_bus.src_b;

endmodule

`default_nettype wire

/* bench/ex_stage_asserts.sv */
`default_nettype none

module ex_stage_asserts (
    input logic clk,
    input logic rst,
    input logic valid_ex_mem,
    input logic pc_update,
    input logic csr_wen_mtvec,
    input logic csr_wen_mepc,
    input logic csr_wen_mcause,
    input logic csr_wen_mstatus
);

    // register cleared, so nothing leaves the stage
    reset_clears: assert property (@(posedge clk)
        rst |=> !valid_ex_mem && !pc_update && !csr_wen_mtvec
                && !csr_wen_mepc && !csr_wen_mcause && !csr_wen_mstatus)
        else $error("stage outputs active in the cycle after reset");

    // empty slot carries op_none, no redirect
    idle_no_redirect: assert property (@(posedge clk) disable iff (rst)
        !valid_ex_mem |-> !pc_update)
        else $error("pc_update raised by an empty slot");

    // one csr address per instruction
    csr_one_target: assert property (@(posedge clk) disable iff (rst)
        !(csr_wen_mtvec && csr_wen_mstatus))
        else $error("mtvec and mstatus written together");

endmodule

bind ex_stage ex_stage_asserts i_ex_stage_asserts (
    .clk             (clk),
    .rst             (rst),
    .valid_ex_mem    (valid_ex_mem),
    .pc_update       (pc_update),
    .csr_wen_mtvec   (csr_wen_mtvec),
    .csr_wen_mepc    (csr_wen_mepc),
    .csr_wen_mcause  (csr_wen_mcause),
    .csr_wen_mstatus (csr_wen_mstatus)
);

`default_nettype wire

/* bench/ex_stage_tb.sv */
`default_nettype none

module ex_stage_tb;
    import ex_pkg::*;

    localparam int n_items    = 2000;
    localparam int wait_limit = 100;

    // kept opcodes plus the empty code
    localparam logic [op_w-1:0] op_table [35] = '{
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
        op_slli, op_srli, op_srai,
        op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_or, op_and,
        op_ld, op_sd, op_csrrw, op_csrrs, op_ecall, op_mret, op_none
    };
    // same order as the enable bits with a last entry that matches nothing
    localparam logic [11:0] csr_table [5] = '{
        csr_mtvec, csr_mepc, csr_mcause, csr_mstatus, 12'h7c0
    };

    typedef struct {
        logic            valid;
        logic [xlen-1:0] pc;
        inst_u           inst;
        logic [op_w-1:0] opcode;
        logic [xlen-1:0] src_a;
        logic [xlen-1:0] src_b;
        logic [xlen-1:0] imm;
    } item_t;

    // wen bits ordered mtvec, mepc, mcause, mstatus from bit 0 up
    typedef struct {
        logic [op_w-1:0]            opcode;
        logic [xlen-1:0]            alu;
        logic                       pc_update;
        logic [xlen-1:0]            dnpc;
        logic [3:0]                 wen;
        logic [3:0][xlen-1:0]       wdata;
    } expect_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              valid_id_ex;
    logic [xlen-1:0]   pc_id_ex;
    logic [inst_w-1:0] inst_id_ex;
    logic [op_w-1:0]   opcode_id_ex;
    logic [xlen-1:0]   src_a;
    logic [xlen-1:0]   src_b;
    logic [xlen-1:0]   imm;
    logic              valid_ex_mem;
    logic [xlen-1:0]   pc_ex_mem;
    logic [inst_w-1:0] inst_ex_mem;
    logic [op_w-1:0]   opcode_ex_mem;
    logic [xlen-1:0]   alu_out_ex_mem;
    logic [xlen-1:0]   src_b_ex_mem;
    logic [xlen-1:0]   dnpc;
    logic              pc_update;
    logic              csr_wen_mtvec;
    logic              csr_wen_mepc;
    logic              csr_wen_mcause;
    logic              csr_wen_mstatus;
    logic [xlen-1:0]   csr_wdata_mtvec;
    logic [xlen-1:0]   csr_wdata_mepc;
    logic [xlen-1:0]   csr_wdata_mcause;
    logic [xlen-1:0]   csr_wdata_mstatus;

    logic [31:0] lfsr_state = 32'h7ba37545;
    item_t       items [$];
    int          checked = 0;

    ex_stage i_ex_stage (
        .clk               (clk),
        .rst               (rst),
        .valid_id_ex       (valid_id_ex),
        .pc_id_ex          (pc_id_ex),
        .inst_id_ex        (inst_id_ex),
        .opcode_id_ex      (opcode_id_ex),
        .src_a             (src_a),
        .src_b             (src_b),
        .imm               (imm),
        .valid_ex_mem      (valid_ex_mem),
        .pc_ex_mem         (pc_ex_mem),
        .inst_ex_mem       (inst_ex_mem),
        .opcode_ex_mem     (opcode_ex_mem),
        .alu_out_ex_mem    (alu_out_ex_mem),
        .src_b_ex_mem      (src_b_ex_mem),
        .dnpc              (dnpc),
        .pc_update         (pc_update),
        .csr_wen_mtvec     (csr_wen_mtvec),
        .csr_wen_mepc      (csr_wen_mepc),
        .csr_wen_mcause    (csr_wen_mcause),
        .csr_wen_mstatus   (csr_wen_mstatus),
        .csr_wdata_mtvec   (csr_wdata_mtvec),
        .csr_wdata_mepc    (csr_wdata_mepc),
        .csr_wdata_mcause  (csr_wdata_mcause),
        .csr_wdata_mstatus (csr_wdata_mstatus)
    );

    // period 8
    always #4 clk = ~clk;

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [xlen-1:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[xlen-2:0], lfsr_state[0]};
        end
    endtask

    task automatic make_item(output item_t it);
        logic [xlen-1:0] r;
        logic [xlen-1:0] w;
        // valid about seven times in eight
        take_bits(3, r);
        it.valid = (r[2:0] != 3'd0);
        take_bits(6, r);
        it.opcode = op_table[int'(r[5:0]) % 35];
        take_bits(xlen, it.pc);
        take_bits(inst_w, w);
        it.inst = w[inst_w-1:0];
        take_bits(xlen, it.src_a);
        take_bits(xlen, it.src_b);
        take_bits(xlen, it.imm);
        // equal operands now and then let beq/bge see the edge case
        take_bits(2, r);
        if (r[1:0] == 2'd0)
            it.src_b = it.src_a;
        // csr ops aim at one of the four csrs or at none
        if (it.opcode == op_csrrw || it.opcode == op_csrrs) begin
            take_bits(3, r);
            it.inst.i_view.csr = csr_table[int'(r[2:0]) % 5];
        end
    endtask

    task automatic drive_item(input item_t it);
        valid_id_ex  = it.valid;
        pc_id_ex     = it.pc;
        inst_id_ex   = it.inst;
        opcode_id_ex = it.opcode;
        src_a        = it.src_a;
        src_b        = it.src_b;
        imm          = it.imm;
    endtask

    // expected stage outputs for one item
    function automatic expect_t model(input item_t it);
        expect_t           e;
        logic [xlen-1:0]   a;
        logic [xlen-1:0]   b;
        logic [xlen-1:0]   diff;
        logic [xlen-1:0]   offset;
        logic [inst_w-1:0] raw;
        logic [5:0]        sh;
        logic              taken;
        a      = it.src_a;
        b      = it.src_b;
        diff   = a - b;
        raw    = it.inst;
        sh     = raw[25:20];
        // b-type offset bits imm[12|10:5] sit at 31:25 and imm[4:1|11] at 11:7
        offset = {{51{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
        e.opcode    = it.valid ? it.opcode : op_none;
        e.pc_update = 1'b0;
        e.dnpc      = '0;
        e.wen       = '0;
        e.wdata     = '0;
        case (e.opcode)
            op_lui:                 e.alu = it.imm;
            op_auipc, op_jal:       e.alu = it.pc + it.imm;
            op_jalr, op_addi,
            op_ld, op_sd:           e.alu = a + it.imm;
            op_slti:                e.alu = ($signed(a) < $signed(it.imm)) ? 64'd1 : 64'd0;
            op_sltiu:               e.alu = (a < it.imm) ? 64'd1 : 64'd0;
            op_xori:                e.alu = a ^ it.imm;
            op_ori:                 e.alu = a | it.imm;
            op_andi:                e.alu = a & it.imm;
            op_slli:                e.alu = a << sh;
            op_srli:                e.alu = a >> sh;
            op_srai:                e.alu = $signed(a) >>> sh;
            op_add:                 e.alu = a + b;
            op_sll:                 e.alu = a << b[5:0];
            op_slt:                 e.alu = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            op_sltu:                e.alu = (a < b) ? 64'd1 : 64'd0;
            op_xor:                 e.alu = a ^ b;
            op_srl:                 e.alu = a >> b[5:0];
            op_or, op_csrrs:        e.alu = a | b;
            op_and:                 e.alu = a & b;
            op_sub, op_beq, op_bne, op_blt,
            op_bge, op_bltu, op_bgeu: e.alu = diff;
            // csrrw, ecall, mret and the empty slot just add
            default:                e.alu = a + b;
        endcase
        // signed branches look at the sign of a - b
        case (e.opcode)
            op_beq:  taken = (a == b);
            op_bne:  taken = (a != b);
            op_blt:  taken = diff[xlen-1];
            op_bge:  taken = !diff[xlen-1];
            op_bltu: taken = (a < b);
            op_bgeu: taken = (a >= b);
            default: taken = 1'b0;
        endcase
        case (e.opcode)
            op_jal: begin
                e.pc_update = 1'b1;
                e.dnpc      = it.pc + it.imm;
            end
            op_jalr: begin
                e.pc_update = 1'b1;
                e.dnpc      = (a + it.imm) & ~64'd1;
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                e.pc_update = 1'b1;
                e.dnpc      = taken ? it.pc + offset : it.pc + 64'd4;
            end
            op_mret: begin
                e.pc_update = 1'b1;
                e.dnpc      = a;
            end
            op_ecall: begin
                e.pc_update = 1'b1;
                e.dnpc      = a;
                e.wen[1]    = 1'b1;
                e.wdata[1]  = it.pc;
                e.wen[2]    = 1'b1;
                e.wdata[2]  = 64'd11;
            end
            op_csrrw, op_csrrs: begin
                for (int k = 0; k < 4; k++) begin
                    if (raw[31:20] == csr_table[k]) begin
                        e.wen[k]   = 1'b1;
                        e.wdata[k] = (e.opcode == op_csrrw) ? a : (a | b);
                    end
                end
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string what, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch at time %0t: %s is %h, expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch at time %0t: %s is %b, expected %b",
                                $time, what, got, exp));
    endtask

    task automatic check_opcode(input logic [op_w-1:0] got, input logic [op_w-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch at time %0t: opcode_ex_mem is %h, expected %h",
                                $time, got, exp));
    endtask

    task automatic check_inst(input logic [inst_w-1:0] got, input logic [inst_w-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch at time %0t: inst_ex_mem is %h, expected %h",
                                $time, got, exp));
    endtask

    // dnpc only matters while a redirect is signalled
    task automatic check_redirect(input logic got_upd, input logic [xlen-1:0] got_pc,
                                  input logic exp_upd, input logic [xlen-1:0] exp_pc);
        check_flag("pc_update", got_upd, exp_upd);
        if (exp_upd)
            check_word("dnpc", got_pc, exp_pc);
    endtask

    task automatic check_csr(input string name, input logic got_wen,
                             input logic [xlen-1:0] got_data,
                             input logic exp_wen, input logic [xlen-1:0] exp_data);
        check_flag({"csr_wen_", name}, got_wen, exp_wen);
        check_word({"csr_wdata_", name}, got_data, exp_data);
    endtask

    // stimulus drives reset and then one item per cycle
    initial begin : stimulus
        item_t it;
        int    waited;
        rst = 1'b1;
        drive_item('{valid: 1'b0, pc: '0, inst: '0, opcode: op_none,
                     src_a: '0, src_b: '0, imm: '0});
        for (int c = 0; c < 4; c++)
            @(posedge clk);
        #1 rst = 1'b0;
        // register still holds its reset contents here
        @(negedge clk);
        check_flag("valid_ex_mem", valid_ex_mem, 1'b0);
        check_opcode(opcode_ex_mem, op_none);
        check_redirect(pc_update, dnpc, 1'b0, '0);
        check_csr("mtvec", csr_wen_mtvec, csr_wdata_mtvec, 1'b0, '0);
        check_csr("mepc", csr_wen_mepc, csr_wdata_mepc, 1'b0, '0);
        check_csr("mcause", csr_wen_mcause, csr_wdata_mcause, 1'b0, '0);
        check_csr("mstatus", csr_wen_mstatus, csr_wdata_mstatus, 1'b0, '0);
        for (int i = 0; i < n_items; i++) begin
            @(posedge clk);
            #1;
            make_item(it);
            drive_item(it);
            items.push_back(it);
        end
        waited = 0;
        while (checked < n_items && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (checked == n_items) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run($sformatf("compare process finished only %0d of %0d items",
                                checked, n_items));
        end
    end

    // item k sits in the register one edge after its drive
    initial begin : compare
        item_t   it;
        expect_t e;
        int      waited;
        waited = 0;
        while (rst || items.size() == 0) begin
            @(posedge clk);
            waited++;
            if (waited > wait_limit)
                abort_run("reset was not released or no stimulus arrived in time");
        end
        while (checked < n_items) begin
            if (items.size() == 0)
                abort_run("compare queue ran empty while items were still due");
            // outputs settled by the falling edge
            @(negedge clk);
            it = items.pop_front();
            e  = model(it);
            check_flag("valid_ex_mem", valid_ex_mem, it.valid);
            check_opcode(opcode_ex_mem, e.opcode);
            check_word("pc_ex_mem", pc_ex_mem, it.pc);
            check_inst(inst_ex_mem, it.inst);
            check_word("src_b_ex_mem", src_b_ex_mem, it.src_b);
            check_word("alu_out_ex_mem", alu_out_ex_mem, e.alu);
            check_redirect(pc_update, dnpc, e.pc_update, e.dnpc);
            check_csr("mtvec", csr_wen_mtvec, csr_wdata_mtvec, e.wen[0], e.wdata[0]);
            check_csr("mepc", csr_wen_mepc, csr_wdata_mepc, e.wen[1], e.wdata[1]);
            check_csr("mcause", csr_wen_mcause, csr_wdata_mcause, e.wen[2], e.wdata[2]);
            check_csr("mstatus", csr_wen_mstatus, csr_wdata_mstatus, e.wen[3], e.wdata[3]);
            checked++;
            @(posedge clk);
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/ex_pkg.sv
logic/ex_bus_if.sv
logic/ex_stage_reg.sv
logic/ex_operand_mux.sv
logic/ex_alu.sv
logic/ex_branch_unit.sv
logic/ex_csr_ctrl.sv
logic/ex_stage.sv
bench/ex_stage_asserts.sv
bench/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - logic/ex_pkg.sv
  - logic/ex_bus_if.sv
  - logic/ex_stage_reg.sv
  - logic/ex_operand_mux.sv
  - logic/ex_alu.sv
  - logic/ex_branch_unit.sv
  - logic/ex_csr_ctrl.sv
  - logic/ex_stage.sv
  - target: simulation
    files:
      - bench/ex_stage_asserts.sv
      - bench/ex_stage_tb.sv
